// File: design/rv_decode_pkg.sv
package rv_decode_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // major opcodes
    localparam opcode_t OPC_I_ALU  = 7'b0010011;
    localparam opcode_t OPC_R      = 7'b0110011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    // funct3, i-type alu
    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_SLTI  = 3'b010;
    localparam logic [2:0] F3_SLTIU = 3'b011;
    localparam logic [2:0] F3_XORI  = 3'b100;
    localparam logic [2:0] F3_ORI   = 3'b110;
    localparam logic [2:0] F3_ANDI  = 3'b111;
    localparam logic [2:0] F3_SLLI  = 3'b001;
    localparam logic [2:0] F3_SRLI  = 3'b101;
    localparam logic [2:0] F3_SRAI  = 3'b101; // same slot as srli, funct7 decides

    // funct3, r-type
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SUB  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_SRA  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3, loads and stores
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // funct3, branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

    typedef enum logic [5:0] {
        EX_NOP = 6'd0,
        EX_ADDI, EX_SLTI, EX_SLTIU, EX_XORI, EX_ORI, EX_ANDI,
        EX_SLLI, EX_SRLI, EX_SRAI,
        EX_ADD, EX_SUB, EX_SLL, EX_SLT, EX_SLTU,
        EX_XOR, EX_SRL, EX_SRA, EX_OR, EX_AND,
        EX_LB, EX_LH, EX_LW, EX_LBU, EX_LHU,
        EX_SB, EX_SH, EX_SW,
        EX_BEQ, EX_BNE, EX_BLT, EX_BGE, EX_BLTU, EX_BGEU
    } ex_code_e;

    typedef enum logic [1:0] {
        IMM_NONE = 2'd0,
        IMM_I    = 2'd1, // alu immediates and loads
        IMM_S    = 2'd2,
        IMM_B    = 2'd3
    } imm_fmt_e;

endpackage

// File: design/ctrl_decoder.sv
`timescale 1ns/1ps

module ctrl_decoder (
    input  rv_decode_pkg::opcode_t  opcode_i,
    input  logic [2:0]              funct3_i,
    input  logic [6:0]              funct7_i,
    output rv_decode_pkg::ex_code_e ex_code_o,
    output rv_decode_pkg::imm_fmt_e imm_fmt_o,
    output logic                    use_rs1_o,
    output logic                    use_rs2_o,
    output logic                    reg_we_o
);

    rv_decode_pkg::ex_code_e ex_code;
    logic                    f7_base;
    logic                    f7_alt;

    assign f7_base = (funct7_i == rv_decode_pkg::F7_BASE);
    assign f7_alt  = (funct7_i == rv_decode_pkg::F7_ALT);

    // execute code only, illegal combinations stay at nop
    always_comb begin
        ex_code = rv_decode_pkg::EX_NOP;
        case (opcode_i)
            rv_decode_pkg::OPC_I_ALU: begin
                case (funct3_i)
                    rv_decode_pkg::F3_ADDI:  ex_code = rv_decode_pkg::EX_ADDI;
                    rv_decode_pkg::F3_SLTI:  ex_code = rv_decode_pkg::EX_SLTI;
                    rv_decode_pkg::F3_SLTIU: ex_code = rv_decode_pkg::EX_SLTIU;
                    rv_decode_pkg::F3_XORI:  ex_code = rv_decode_pkg::EX_XORI;
                    rv_decode_pkg::F3_ORI:   ex_code = rv_decode_pkg::EX_ORI;
                    rv_decode_pkg::F3_ANDI:  ex_code = rv_decode_pkg::EX_ANDI;
                    rv_decode_pkg::F3_SLLI: begin
                        if (f7_base)
                            ex_code = rv_decode_pkg::EX_SLLI;
                    end
                    rv_decode_pkg::F3_SRLI: begin // also srai
                        if (f7_base)
                            ex_code = rv_decode_pkg::EX_SRLI;
                        else if (f7_alt)
                            ex_code = rv_decode_pkg::EX_SRAI;
                    end
                    default: ex_code = rv_decode_pkg::EX_NOP;
                endcase
            end
            rv_decode_pkg::OPC_R: begin
                case (funct3_i)
                    rv_decode_pkg::F3_ADD: begin // also sub
                        if (f7_base)
                            ex_code = rv_decode_pkg::EX_ADD;
                        else if (f7_alt)
                            ex_code = rv_decode_pkg::EX_SUB;
                    end
                    rv_decode_pkg::F3_SRL: begin // also sra
                        if (f7_base)
                            ex_code = rv_decode_pkg::EX_SRL;
                        else if (f7_alt)
                            ex_code = rv_decode_pkg::EX_SRA;
                    end
                    rv_decode_pkg::F3_SLL:  ex_code = f7_base ? rv_decode_pkg::EX_SLL
                                                              : rv_decode_pkg::EX_NOP;
                    rv_decode_pkg::F3_SLT:  ex_code = f7_base ? rv_decode_pkg::EX_SLT
                                                              : rv_decode_pkg::EX_NOP;
                    rv_decode_pkg::F3_SLTU: ex_code = f7_base ? rv_decode_pkg::EX_SLTU
                                                              : rv_decode_pkg::EX_NOP;
                    rv_decode_pkg::F3_XOR:  ex_code = f7_base ? rv_decode_pkg::EX_XOR
                                                              : rv_decode_pkg::EX_NOP;
                    rv_decode_pkg::F3_OR:   ex_code = f7_base ? rv_decode_pkg::EX_OR
                                                              : rv_decode_pkg::EX_NOP;
                    rv_decode_pkg::F3_AND:  ex_code = f7_base ? rv_decode_pkg::EX_AND
                                                              : rv_decode_pkg::EX_NOP;
                    default: ex_code = rv_decode_pkg::EX_NOP;
                endcase
            end
            rv_decode_pkg::OPC_LOAD: begin
                case (funct3_i)
                    rv_decode_pkg::F3_LB:  ex_code = rv_decode_pkg::EX_LB;
                    rv_decode_pkg::F3_LH:  ex_code = rv_decode_pkg::EX_LH;
                    rv_decode_pkg::F3_LW:  ex_code = rv_decode_pkg::EX_LW;
                    rv_decode_pkg::F3_LBU: ex_code = rv_decode_pkg::EX_LBU;
                    rv_decode_pkg::F3_LHU: ex_code = rv_decode_pkg::EX_LHU;
                    default: ex_code = rv_decode_pkg::EX_NOP;
                endcase
            end
            rv_decode_pkg::OPC_STORE: begin
                case (funct3_i)
                    rv_decode_pkg::F3_SB: ex_code = rv_decode_pkg::EX_SB;
                    rv_decode_pkg::F3_SH: ex_code = rv_decode_pkg::EX_SH;
                    rv_decode_pkg::F3_SW: ex_code = rv_decode_pkg::EX_SW;
                    default: ex_code = rv_decode_pkg::EX_NOP;
                endcase
            end
            rv_decode_pkg::OPC_BRANCH: begin
                case (funct3_i)
                    rv_decode_pkg::F3_BEQ:  ex_code = rv_decode_pkg::EX_BEQ;
                    rv_decode_pkg::F3_BNE:  ex_code = rv_decode_pkg::EX_BNE;
                    rv_decode_pkg::F3_BLT:  ex_code = rv_decode_pkg::EX_BLT;
                    rv_decode_pkg::F3_BGE:  ex_code = rv_decode_pkg::EX_BGE;
                    rv_decode_pkg::F3_BLTU: ex_code = rv_decode_pkg::EX_BLTU;
                    rv_decode_pkg::F3_BGEU: ex_code = rv_decode_pkg::EX_BGEU;
                    default: ex_code = rv_decode_pkg::EX_NOP;
                endcase
            end
            default: ex_code = rv_decode_pkg::EX_NOP;
        endcase
    end

    // per-class attributes, all off for nop
    always_comb begin
        imm_fmt_o = rv_decode_pkg::IMM_NONE;
        use_rs1_o = 1'b0;
        use_rs2_o = 1'b0;
        reg_we_o  = 1'b0;
        if (ex_code != rv_decode_pkg::EX_NOP) begin
            case (opcode_i)
                rv_decode_pkg::OPC_I_ALU,
                rv_decode_pkg::OPC_LOAD: begin
                    imm_fmt_o = rv_decode_pkg::IMM_I;
                    use_rs1_o = 1'b1;
                    reg_we_o  = 1'b1;
                end
                rv_decode_pkg::OPC_R: begin
                    use_rs1_o = 1'b1;
                    use_rs2_o = 1'b1;
                    reg_we_o  = 1'b1;
                end
                rv_decode_pkg::OPC_STORE: begin
                    imm_fmt_o = rv_decode_pkg::IMM_S;
                    use_rs1_o = 1'b1;
                    use_rs2_o = 1'b1;
                end
                rv_decode_pkg::OPC_BRANCH: begin
                    imm_fmt_o = rv_decode_pkg::IMM_B;
                    use_rs1_o = 1'b1;
                    use_rs2_o = 1'b1;
                end
                default: imm_fmt_o = rv_decode_pkg::IMM_NONE;
            endcase
        end
    end

    assign ex_code_o = ex_code;

endmodule

// File: design/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  rv_decode_pkg::inst_t    inst_i,
    input  rv_decode_pkg::imm_fmt_e imm_fmt_i,
    output rv_decode_pkg::word_t    imm_o
);

    rv_decode_pkg::word_t imm_i_type;
    rv_decode_pkg::word_t imm_s_type;
    rv_decode_pkg::word_t imm_b_type;

    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};

    // bit 0 always zero, halfword aligned offset
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};

    always_comb begin
        case (imm_fmt_i)
            rv_decode_pkg::IMM_I: imm_o = imm_i_type;
            rv_decode_pkg::IMM_S: imm_o = imm_s_type;
            rv_decode_pkg::IMM_B: imm_o = imm_b_type;
            default:              imm_o = '0;
        endcase
    end

endmodule

// File: design/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       valid_i,
    input  rv_decode_pkg::inst_t       inst_i,
    input  rv_decode_pkg::word_t       reg1_rdata_i,
    input  rv_decode_pkg::word_t       reg2_rdata_i,

    output rv_decode_pkg::reg_addr_t   reg1_raddr_o,
    output rv_decode_pkg::reg_addr_t   reg2_raddr_o,

    output logic                       valid_o,
    output logic                       reg_we_o,
    output rv_decode_pkg::reg_addr_t   reg_waddr_o,
    output rv_decode_pkg::ex_code_e    ex_code_o,
    output rv_decode_pkg::word_t       imm_o,
    output rv_decode_pkg::word_t       reg1_rdata_o,
    output rv_decode_pkg::word_t       reg2_rdata_o
);

    rv_decode_pkg::opcode_t    opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    rv_decode_pkg::reg_addr_t  rd;
    rv_decode_pkg::reg_addr_t  rs1;
    rv_decode_pkg::reg_addr_t  rs2;

    rv_decode_pkg::ex_code_e   ex_code;
    rv_decode_pkg::imm_fmt_e   imm_fmt;
    rv_decode_pkg::word_t      imm;
    rv_decode_pkg::reg_addr_t  waddr;
    logic                      use_rs1;
    logic                      use_rs2;
    logic                      reg_we;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];

    ctrl_decoder u_ctrl_decoder (
        .opcode_i  (opcode),
        .funct3_i  (funct3),
        .funct7_i  (funct7),
        .ex_code_o (ex_code),
        .imm_fmt_o (imm_fmt),
        .use_rs1_o (use_rs1),
        .use_rs2_o (use_rs2),
        .reg_we_o  (reg_we)
    );

    imm_gen u_imm_gen (
        .inst_i    (inst_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm)
    );

    // unused sources read x0, regfile answers in the same cycle
    assign reg1_raddr_o = use_rs1 ? rs1 : '0;
    assign reg2_raddr_o = use_rs2 ? rs2 : '0;
    assign waddr        = reg_we ? rd : '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o      <= 1'b0;
            reg_we_o     <= 1'b0;
            reg_waddr_o  <= '0;
            ex_code_o    <= rv_decode_pkg::EX_NOP;
            imm_o        <= '0;
            reg1_rdata_o <= '0;
            reg2_rdata_o <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin // hold bundle while idle
                reg_we_o     <= reg_we;
                reg_waddr_o  <= waddr;
                ex_code_o    <= ex_code;
                imm_o        <= imm;
                reg1_rdata_o <= reg1_rdata_i;
                reg2_rdata_o <= reg2_rdata_i;
            end
        end
    end

endmodule

// File: include/id_tb_encode.svh
`ifndef ID_TB_ENCODE_SVH
`define ID_TB_ENCODE_SVH

function automatic rv_decode_pkg::inst_t r_format(input logic [6:0] f7,
                                                  input rv_decode_pkg::reg_addr_t rs2,
                                                  input rv_decode_pkg::reg_addr_t rs1,
                                                  input logic [2:0] f3,
                                                  input rv_decode_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, rv_decode_pkg::OPC_R};
endfunction

function automatic rv_decode_pkg::inst_t i_format(input logic [11:0] imm,
                                                  input rv_decode_pkg::reg_addr_t rs1,
                                                  input logic [2:0] f3,
                                                  input rv_decode_pkg::reg_addr_t rd,
                                                  input rv_decode_pkg::opcode_t opc);
    return {imm, rs1, f3, rd, opc}; // shifts carry funct7 in imm[11:5]
endfunction

function automatic rv_decode_pkg::inst_t s_format(input logic [11:0] imm,
                                                  input rv_decode_pkg::reg_addr_t rs2,
                                                  input rv_decode_pkg::reg_addr_t rs1,
                                                  input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_decode_pkg::OPC_STORE};
endfunction

// imm[0] is not encoded
function automatic rv_decode_pkg::inst_t b_format(input logic [12:0] imm,
                                                  input rv_decode_pkg::reg_addr_t rs2,
                                                  input rv_decode_pkg::reg_addr_t rs1,
                                                  input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_decode_pkg::OPC_BRANCH};
endfunction

function automatic rv_decode_pkg::inst_t u_format(input logic [19:0] imm,
                                                  input rv_decode_pkg::reg_addr_t rd,
                                                  input rv_decode_pkg::opcode_t opc);
    return {imm, rd, opc};
endfunction

`endif

// File: tests/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int REPS         = 4;
    localparam int NUM_BAD      = 10;
    localparam int STREAM_LEN   = 80;
    localparam int NUM_INSTR    = 33 * REPS + NUM_BAD + STREAM_LEN;
    localparam int LIMIT_NS     = (NUM_INSTR * 2 + RESET_CYCLES + 20) * CLK_PERIOD;
    localparam int CL_R = 0;
    localparam int CL_I = 1;
    localparam int CL_S = 2;
    localparam int CL_B = 3;

    typedef struct packed {
        logic                      valid;
        logic                      we;
        rv_decode_pkg::reg_addr_t  waddr;
        rv_decode_pkg::ex_code_e   ex;
        rv_decode_pkg::word_t      imm;
        rv_decode_pkg::reg_addr_t  ra1;
        rv_decode_pkg::reg_addr_t  ra2;
    } bundle_t;

    logic clk;
    logic rst_n;
    logic valid;
    rv_decode_pkg::inst_t      inst;
    rv_decode_pkg::word_t      rf_rdata1;
    rv_decode_pkg::word_t      rf_rdata2;
    rv_decode_pkg::reg_addr_t  reg1_raddr;
    rv_decode_pkg::reg_addr_t  reg2_raddr;
    logic                      valid_o;
    logic                      reg_we_o;
    rv_decode_pkg::reg_addr_t  reg_waddr_o;
    rv_decode_pkg::ex_code_e   ex_code_o;
    rv_decode_pkg::word_t      imm_o;
    rv_decode_pkg::word_t      reg1_rdata_o;
    rv_decode_pkg::word_t      reg2_rdata_o;

    rv_decode_pkg::word_t seed = 32'h8d18_f575;
    bundle_t pending[$]; // one prediction in flight
    bundle_t last;
    // funct3 per execute code, EX_ADDI up to EX_BGEU
    logic [2:0] f3_tab [1:33] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5,
                                  3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7,
                                  3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd0, 3'd1, 3'd2,
                                  3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    `include "id_tb_encode.svh"

    id_stage uut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .valid_i      (valid),
        .inst_i       (inst),
        .reg1_rdata_i (rf_rdata1),
        .reg2_rdata_i (rf_rdata2),
        .reg1_raddr_o (reg1_raddr),
        .reg2_raddr_o (reg2_raddr),
        .valid_o      (valid_o),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .ex_code_o    (ex_code_o),
        .imm_o        (imm_o),
        .reg1_rdata_o (reg1_rdata_o),
        .reg2_rdata_o (reg2_rdata_o)
    );

    function automatic rv_decode_pkg::word_t rf_data(input rv_decode_pkg::reg_addr_t a);
        if (a == '0)
            return '0; // x0
        return {a, 27'h0} ^ ({27'h0, a} * 32'h0101_0101) ^ 32'h3c6e_f372;
    endfunction

    assign rf_rdata1 = rf_data(reg1_raddr);
    assign rf_rdata2 = rf_data(reg2_raddr);

    function automatic rv_decode_pkg::word_t next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic bundle_t predict(input int cls, input rv_decode_pkg::ex_code_e code,
                                        input rv_decode_pkg::reg_addr_t rd,
                                        input rv_decode_pkg::reg_addr_t rs1,
                                        input rv_decode_pkg::reg_addr_t rs2,
                                        input logic [12:0] imm);
        bundle_t b;
        b = '0;
        b.valid = 1'b1; // nop is still a valid slot
        if (code != rv_decode_pkg::EX_NOP) begin
            b.ex = code;
            b.ra1 = rs1;
            b.ra2 = (cls == CL_I) ? '0 : rs2;
            b.we = (cls == CL_R || cls == CL_I);
            b.waddr = b.we ? rd : '0;
            case (cls)
                CL_I, CL_S: b.imm = {{20{imm[11]}}, imm[11:0]};
                CL_B:       b.imm = {{19{imm[12]}}, imm[12:1], 1'b0};
                default:    b.imm = '0;
            endcase
        end
        return b;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input rv_decode_pkg::word_t got,
                              input rv_decode_pkg::word_t exp);
        assert (got === exp)
        else stop_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic compare_outputs(input bundle_t e);
        assert (valid_o === e.valid)
        else stop_run(e.valid ? "valid_o stayed low one cycle after an accepted instruction"
                              : "valid_o went high with no instruction one cycle earlier");
        check_word("ex_code_o", 32'(ex_code_o), 32'(e.ex));
        check_word("reg_we_o", 32'(reg_we_o), 32'(e.we));
        check_word("reg_waddr_o", 32'(reg_waddr_o), 32'(e.waddr));
        check_word("imm_o", imm_o, e.imm);
        check_word("reg1_rdata_o", reg1_rdata_o, rf_data(e.ra1));
        check_word("reg2_rdata_o", reg2_rdata_o, rf_data(e.ra2));
    endtask

    // called on a falling edge, returns on the next one
    task automatic step(input logic v, input rv_decode_pkg::inst_t w, input bundle_t b);
        bundle_t nxt;
        compare_outputs(pending.pop_front());
        valid = v;
        inst = w;
        nxt = last;
        nxt.valid = 1'b0; // idle keeps the old bundle
        if (v) begin
            nxt = b;
            #1;
            check_word("reg1_raddr_o", 32'(reg1_raddr), 32'(b.ra1));
            check_word("reg2_raddr_o", 32'(reg2_raddr), 32'(b.ra2));
        end
        last = nxt;
        pending.push_back(nxt);
        @(negedge clk);
    endtask

    task automatic issue_kind(input int k);
        rv_decode_pkg::word_t r;
        rv_decode_pkg::reg_addr_t rd;
        rv_decode_pkg::reg_addr_t rs1;
        rv_decode_pkg::reg_addr_t rs2;
        logic [12:0] imm;
        logic [6:0] f7;
        rv_decode_pkg::inst_t w;
        int cls;
        r = next_rand();
        rd = r[31:27];
        rs1 = r[26:22];
        rs2 = r[21:17];
        imm = r[16:4];
        f7 = (k == 9 || k == 11 || k == 17) ? 7'h20 : 7'h00; // srai, sub, sra
        if (k <= 9) begin
            cls = CL_I;
            if (k >= 7)
                imm[11:0] = {f7, imm[4:0]};
            w = i_format(imm[11:0], rs1, f3_tab[k], rd, rv_decode_pkg::OPC_I_ALU);
        end else if (k <= 19) begin
            cls = CL_R;
            w = r_format(f7, rs2, rs1, f3_tab[k], rd);
        end else if (k <= 24) begin
            cls = CL_I;
            w = i_format(imm[11:0], rs1, f3_tab[k], rd, rv_decode_pkg::OPC_LOAD);
        end else if (k <= 27) begin
            cls = CL_S;
            w = s_format(imm[11:0], rs2, rs1, f3_tab[k]);
        end else begin
            cls = CL_B;
            w = b_format(imm, rs2, rs1, f3_tab[k]);
        end
        step(1'b1, w, predict(cls, rv_decode_pkg::ex_code_e'(k), rd, rs1, rs2, imm));
    endtask

    task automatic issue_bad(input rv_decode_pkg::inst_t w);
        step(1'b1, w, predict(CL_R, rv_decode_pkg::EX_NOP, '0, '0, '0, '0));
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout: the test sequence did not finish in time");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    initial begin
        int k;
        rv_decode_pkg::word_t r;
        rst_n = 1'b0;
        valid = 1'b0;
        inst = '0;
        last = '0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_outputs('0);
        end
        rst_n = 1'b1;
        pending.push_back('0);
        step(1'b0, '0, '0); // first cycle out of reset stays idle
        for (k = 1; k <= 33; k++)
            repeat (REPS) issue_kind(k);
        r = next_rand();
        issue_bad(u_format(r[31:12], r[11:7], rv_decode_pkg::OPC_LUI));
        issue_bad(u_format(r[31:12], r[11:7], rv_decode_pkg::OPC_AUIPC));
        issue_bad(i_format(r[31:20], r[19:15], r[14:12], r[11:7], 7'h7f));
        issue_bad(i_format(r[31:20], r[19:15], 3'd6, r[11:7], rv_decode_pkg::OPC_LOAD));
        issue_bad(s_format(r[31:20], r[24:20], r[19:15], 3'd4));
        issue_bad(b_format(r[31:19], r[24:20], r[19:15], 3'd2));
        issue_bad(r_format(7'h01, r[24:20], r[19:15], 3'd0, r[11:7])); // add
        issue_bad(r_format(7'h20, r[24:20], r[19:15], 3'd4, r[11:7])); // xor
        issue_bad(i_format({7'h20, r[24:20]}, r[19:15], 3'd1, r[11:7],
                           rv_decode_pkg::OPC_I_ALU)); // slli
        issue_bad(i_format({7'h01, r[24:20]}, r[19:15], 3'd5, r[11:7],
                           rv_decode_pkg::OPC_I_ALU)); // srli
        repeat (STREAM_LEN) begin
            k = 1 + int'(next_rand() % 32'd33);
            issue_kind(k);
            if (next_rand() > 32'h9000_0000)
                step(1'b0, next_rand(), '0); // idle with junk on inst
        end
        compare_outputs(pending.pop_front());
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: id_stage.f
+incdir+include
design/rv_decode_pkg.sv
design/ctrl_decoder.sv
design/imm_gen.sv
design/id_stage.sv
tests/id_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the id_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f id_stage.f --top-module id_stage_tb \
    -o id_stage_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/id_stage_sim > sim.log 2>&1

grep -q "^PASS: all tests$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
